// ==== Makefile ====
# Verilator build and run of the HACD testbench

VERILATOR ?= verilator
FILELIST  ?= filelist.f
TB_TOP    ?= tb_hacd
RTL_TOP   ?= hacd
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only -Wall

RTL_SRCS := $(shell grep '^hdl/' $(FILELIST))

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TB_TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o V$(TB_TOP)

run: build
	-./$(BUILD_DIR)/V$(TB_TOP) 2>&1 | tee $(LOG)
	@if grep -q "Done: errors found" $(LOG); then \
		echo "Simulation FAILED"; exit 1; \
	fi
	@if ! grep -q "Done: no errors" $(LOG); then \
		echo "Simulation ended without a result"; exit 1; \
	fi
	@echo "Simulation PASSED"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) $(RTL_SRCS)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== filelist.f ====
hdl/hacd_reg_pkg.sv
hdl/hacd_comp_pkg.sv
hdl/hacd_regs.sv
hdl/hacd_run_encoder.sv
hdl/hacd_page_monitor.sv
hdl/hacd.sv
sim/tb_hacd.sv

// ==== hdl/hacd.sv ====
`timescale 1ns/1ps

module hacd (
  input  logic                                clk_i,
  input  logic                                rst_n_i,
  // Register bus
  input  logic                                reg_valid_i,
  input  logic                                reg_write_i,
  input  logic [hacd_reg_pkg::REG_ADDR_W-1:0] reg_addr_i,
  input  logic [hacd_reg_pkg::REG_DATA_W-1:0] reg_wdata_i,
  input  logic [hacd_reg_pkg::REG_STRB_W-1:0] reg_wstrb_i,
  output logic [hacd_reg_pkg::REG_DATA_W-1:0] reg_rdata_o,
  output logic                                reg_ready_o,
  output logic                                reg_error_o,
  // Word stream in
  input  logic                                word_valid_i,
  input  logic [hacd_comp_pkg::WORD_W-1:0]    word_data_i,
  input  logic                                word_last_i,
  // Token stream out
  output logic                                tok_valid_o,
  output logic [hacd_comp_pkg::RUN_W-1:0]     tok_run_o,
  output logic [hacd_comp_pkg::WORD_W-1:0]    tok_data_o,
  output logic                                tok_lit_o,
  output logic                                tok_last_o,
  // Interrupts
  output logic                                defl_interrupt_o,
  output logic                                infl_interrupt_o
);

  //////////////////////////////////////////////////////////////////////
  // Internal wires
  //////////////////////////////////////////////////////////////////////

  // Register block to pipeline
  logic                            comp_en;
  logic [hacd_comp_pkg::RUN_W-1:0] low_wm;
  // Page monitor back to the register block
  logic                            page_done;
  logic                            page_compressible;
  logic [hacd_comp_pkg::RUN_W-1:0] page_tokens;

  // Control, watermark, status and interrupts
  hacd_regs i_regs (
    .clk_i               (clk_i),
    .rst_n_i             (rst_n_i),
    .reg_valid_i         (reg_valid_i),
    .reg_write_i         (reg_write_i),
    .reg_addr_i          (reg_addr_i),
    .reg_wdata_i         (reg_wdata_i),
    .reg_wstrb_i         (reg_wstrb_i),
    .reg_rdata_o         (reg_rdata_o),
    .reg_ready_o         (reg_ready_o),
    .reg_error_o         (reg_error_o),
    .page_done_i         (page_done),
    .page_compressible_i (page_compressible),
    .page_tokens_i       (page_tokens),
    .comp_en_o           (comp_en),
    .low_wm_o            (low_wm),
    .defl_interrupt_o    (defl_interrupt_o),
    .infl_interrupt_o    (infl_interrupt_o)
  );

  // Word to token, two cycles
  hacd_run_encoder i_run_encoder (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .comp_en_i    (comp_en),
    .word_valid_i (word_valid_i),
    .word_last_i  (word_last_i),
    .word_data_i  (word_data_i),
    .tok_valid_o  (tok_valid_o),
    .tok_lit_o    (tok_lit_o),
    .tok_last_o   (tok_last_o),
    .tok_run_o    (tok_run_o),
    .tok_data_o   (tok_data_o)
  );

  // Watches the same token stream the consumer sees
  hacd_page_monitor i_page_monitor (
    .clk_i               (clk_i),
    .rst_n_i             (rst_n_i),
    .tok_valid_i         (tok_valid_o),
    .tok_last_i          (tok_last_o),
    .low_wm_i            (low_wm),
    .page_done_o         (page_done),
    .page_compressible_o (page_compressible),
    .page_tokens_o       (page_tokens)
  );

endmodule

// ==== hdl/hacd_comp_pkg.sv ====
package hacd_comp_pkg;

  // Datapath sizes of the zero-run compressor

  //////////////////////////////////////////////////////////////////////
  // Stream sizes
  //////////////////////////////////////////////////////////////////////

  // Memory word carried on the input stream and in literal tokens
  localparam int unsigned WORD_W = 32;

  // Largest page in words
  localparam int unsigned PAGE_WORDS_MAX = 64;

  // Run count and page token count share one width
  // Must hold PAGE_WORDS_MAX itself
  // An all-zero page gives that run
  localparam int unsigned RUN_W = $clog2(PAGE_WORDS_MAX + 1);

endpackage

// ==== hdl/hacd_page_monitor.sv ====
`timescale 1ns/1ps

module hacd_page_monitor (
  input  logic                            clk_i,
  input  logic                            rst_n_i,
  // Token stream
  input  logic                            tok_valid_i,
  input  logic                            tok_last_i,
  // Threshold from the register block
  input  logic [hacd_comp_pkg::RUN_W-1:0] low_wm_i,
  // Page result
  output logic                            page_done_o,
  output logic                            page_compressible_o,
  output logic [hacd_comp_pkg::RUN_W-1:0] page_tokens_o
);

  logic [hacd_comp_pkg::RUN_W-1:0] cnt_q;
  logic [hacd_comp_pkg::RUN_W-1:0] cnt_inc;
  logic                            page_end;
  logic                            done_q;
  logic                            comp_q;
  logic [hacd_comp_pkg::RUN_W-1:0] total_q;

  // Running total including the current token
  assign cnt_inc  = cnt_q + 1'b1;
  assign page_end = tok_valid_i & tok_last_i;

  //////////////////////////////////////////////////////////////////////
  // Token count per page
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      cnt_q  <= '0;
      done_q <= 1'b0;
    end else begin
      done_q <= page_end;
      // Restart at page end
      if (page_end) begin
        cnt_q <= '0;
      end else if (tok_valid_i) begin
        cnt_q <= cnt_inc;
      end
    end
  end

  // Result held with the done pulse
  always_ff @(posedge clk_i) begin
    if (page_end) begin
      total_q <= cnt_inc;
      // At or below the watermark compresses
      comp_q  <= (cnt_inc <= low_wm_i);
    end
  end

  assign page_done_o         = done_q;
  assign page_compressible_o = comp_q;
  assign page_tokens_o       = total_q;

endmodule

// ==== hdl/hacd_reg_pkg.sv ====
package hacd_reg_pkg;

  // Register map of the HACD register block
  // Byte offsets on the request/response bus with field positions and reset values

  //////////////////////////////////////////////////////////////////////
  // Bus geometry
  //////////////////////////////////////////////////////////////////////

  localparam int unsigned REG_ADDR_W = 32;
  localparam int unsigned REG_DATA_W = 32;
  // One strobe per data byte
  localparam int unsigned REG_STRB_W = REG_DATA_W / 8;

  //////////////////////////////////////////////////////////////////////
  // Register offsets
  //////////////////////////////////////////////////////////////////////

  localparam logic [REG_ADDR_W-1:0] ADDR_CTRL        = 32'h0000_0000;
  localparam logic [REG_ADDR_W-1:0] ADDR_LOW_WM      = 32'h0000_0004;
  // Write one to clear
  localparam logic [REG_ADDR_W-1:0] ADDR_STATUS      = 32'h0000_0008;
  // Read only
  localparam logic [REG_ADDR_W-1:0] ADDR_PAGE_TOKENS = 32'h0000_000C;

  //////////////////////////////////////////////////////////////////////
  // Field positions
  //////////////////////////////////////////////////////////////////////

  // Control register
  localparam int unsigned CTRL_W           = 3;
  localparam int unsigned CTRL_COMP_EN_BIT = 0;
  localparam int unsigned CTRL_DEFL_IE_BIT = 1;
  localparam int unsigned CTRL_INFL_IE_BIT = 2;

  // Status register with sticky pending bits
  localparam int unsigned STAT_DEFL_BIT = 0;
  localparam int unsigned STAT_INFL_BIT = 1;

  // Reset values
  localparam logic [REG_DATA_W-1:0] CTRL_RESET   = 32'd0;
  localparam logic [REG_DATA_W-1:0] LOW_WM_RESET = 32'd16;

endpackage

// ==== hdl/hacd_regs.sv ====
`timescale 1ns/1ps

module hacd_regs (
  input  logic                                clk_i,
  input  logic                                rst_n_i,
  // Request/response bus
  input  logic                                reg_valid_i,
  input  logic                                reg_write_i,
  input  logic [hacd_reg_pkg::REG_ADDR_W-1:0] reg_addr_i,
  input  logic [hacd_reg_pkg::REG_DATA_W-1:0] reg_wdata_i,
  input  logic [hacd_reg_pkg::REG_STRB_W-1:0] reg_wstrb_i,
  output logic [hacd_reg_pkg::REG_DATA_W-1:0] reg_rdata_o,
  output logic                                reg_ready_o,
  output logic                                reg_error_o,
  // Page results from the monitor
  input  logic                                page_done_i,
  input  logic                                page_compressible_i,
  input  logic [hacd_comp_pkg::RUN_W-1:0]     page_tokens_i,
  // Pipeline controls
  output logic                                comp_en_o,
  output logic [hacd_comp_pkg::RUN_W-1:0]     low_wm_o,
  // Interrupts
  output logic                                defl_interrupt_o,
  output logic                                infl_interrupt_o
);

  // Byte-lane merge of write data into a register value
  function automatic logic [hacd_reg_pkg::REG_DATA_W-1:0] strb_merge(
    input logic [hacd_reg_pkg::REG_DATA_W-1:0] old_v,
    input logic [hacd_reg_pkg::REG_DATA_W-1:0] new_v,
    input logic [hacd_reg_pkg::REG_STRB_W-1:0] strb
  );
    logic [hacd_reg_pkg::REG_DATA_W-1:0] res;
    res = old_v;
    for (int b = 0; b < hacd_reg_pkg::REG_STRB_W; b++) begin
      if (strb[b]) begin
        res[8*b +: 8] = new_v[8*b +: 8];
      end
    end
    return res;
  endfunction

  // Register state
  logic [hacd_reg_pkg::CTRL_W-1:0]     ctrl_q;
  logic [hacd_comp_pkg::RUN_W-1:0]     low_wm_q;
  logic                                defl_pend_q;
  logic                                infl_pend_q;
  logic [hacd_comp_pkg::RUN_W-1:0]     page_tokens_q;
  // Response
  logic                                ready_q;
  logic                                error_q;
  logic [hacd_reg_pkg::REG_DATA_W-1:0] rdata_q;

  logic                                req_take;
  logic                                hit_ctrl;
  logic                                hit_wm;
  logic                                hit_stat;
  logic                                hit_tok;
  logic                                hit_any;
  logic [hacd_reg_pkg::REG_DATA_W-1:0] ctrl_rd;
  logic [hacd_reg_pkg::REG_DATA_W-1:0] wm_rd;
  logic [hacd_reg_pkg::REG_DATA_W-1:0] stat_rd;
  logic [hacd_reg_pkg::REG_DATA_W-1:0] tok_rd;
  logic [hacd_reg_pkg::REG_DATA_W-1:0] rd_mux;
  logic [hacd_reg_pkg::REG_DATA_W-1:0] ctrl_wr;
  logic [hacd_reg_pkg::REG_DATA_W-1:0] wm_wr;
  logic [hacd_reg_pkg::REG_DATA_W-1:0] stat_wmask;
  logic                                wr_ctrl;
  logic                                wr_wm;
  logic                                defl_clr;
  logic                                infl_clr;
  logic                                defl_set;
  logic                                infl_set;

  //////////////////////////////////////////////////////////////////////
  // Address decode and read data
  //////////////////////////////////////////////////////////////////////

  // New request, taken once while ready is low
  assign req_take = reg_valid_i & ~ready_q;

  assign hit_ctrl = (reg_addr_i == hacd_reg_pkg::ADDR_CTRL);
  assign hit_wm   = (reg_addr_i == hacd_reg_pkg::ADDR_LOW_WM);
  assign hit_stat = (reg_addr_i == hacd_reg_pkg::ADDR_STATUS);
  assign hit_tok  = (reg_addr_i == hacd_reg_pkg::ADDR_PAGE_TOKENS);
  assign hit_any  = hit_ctrl | hit_wm | hit_stat | hit_tok;

  always_comb begin
    // Zero-extended views of each register
    ctrl_rd = '0;
    ctrl_rd[hacd_reg_pkg::CTRL_W-1:0] = ctrl_q;
    wm_rd = '0;
    wm_rd[hacd_comp_pkg::RUN_W-1:0] = low_wm_q;
    stat_rd = '0;
    stat_rd[hacd_reg_pkg::STAT_DEFL_BIT] = defl_pend_q;
    stat_rd[hacd_reg_pkg::STAT_INFL_BIT] = infl_pend_q;
    tok_rd = '0;
    tok_rd[hacd_comp_pkg::RUN_W-1:0] = page_tokens_q;
    // Unmapped reads return zero
    rd_mux = '0;
    if (hit_ctrl) rd_mux = ctrl_rd;
    if (hit_wm)   rd_mux = wm_rd;
    if (hit_stat) rd_mux = stat_rd;
    if (hit_tok)  rd_mux = tok_rd;
  end

  //////////////////////////////////////////////////////////////////////
  // Write path
  //////////////////////////////////////////////////////////////////////

  // Merged values, only the low field bits are kept
  assign ctrl_wr = strb_merge(ctrl_rd, reg_wdata_i, reg_wstrb_i);
  assign wm_wr   = strb_merge(wm_rd, reg_wdata_i, reg_wstrb_i);
  // Strobed ones of the write data select bits to clear
  assign stat_wmask = strb_merge('0, reg_wdata_i, reg_wstrb_i);

  assign wr_ctrl  = req_take & reg_write_i & hit_ctrl;
  assign wr_wm    = req_take & reg_write_i & hit_wm;
  assign defl_clr = req_take & reg_write_i & hit_stat &
                    stat_wmask[hacd_reg_pkg::STAT_DEFL_BIT];
  assign infl_clr = req_take & reg_write_i & hit_stat &
                    stat_wmask[hacd_reg_pkg::STAT_INFL_BIT];

  // Page end classification
  assign defl_set = page_done_i & page_compressible_i;
  assign infl_set = page_done_i & ~page_compressible_i;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      ctrl_q        <= hacd_reg_pkg::CTRL_RESET[hacd_reg_pkg::CTRL_W-1:0];
      low_wm_q      <= hacd_reg_pkg::LOW_WM_RESET[hacd_comp_pkg::RUN_W-1:0];
      defl_pend_q   <= 1'b0;
      infl_pend_q   <= 1'b0;
      page_tokens_q <= '0;
    end else begin
      if (wr_ctrl) ctrl_q <= ctrl_wr[hacd_reg_pkg::CTRL_W-1:0];
      if (wr_wm)   low_wm_q <= wm_wr[hacd_comp_pkg::RUN_W-1:0];
      // Set wins over a clear in the same cycle
      defl_pend_q <= (defl_pend_q & ~defl_clr) | defl_set;
      infl_pend_q <= (infl_pend_q & ~infl_clr) | infl_set;
      if (page_done_i) page_tokens_q <= page_tokens_i;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Response
  //////////////////////////////////////////////////////////////////////

  // One-cycle ready pulse, error aligned with it
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      ready_q <= 1'b0;
      error_q <= 1'b0;
    end else begin
      ready_q <= req_take;
      error_q <= req_take & ~hit_any;
    end
  end

  // Read data captured with the request
  always_ff @(posedge clk_i) begin
    if (req_take) rdata_q <= reg_write_i ? '0 : rd_mux;
  end

  assign reg_ready_o = ready_q;
  assign reg_error_o = error_q;
  assign reg_rdata_o = rdata_q;

  // Controls into the pipeline
  assign comp_en_o = ctrl_q[hacd_reg_pkg::CTRL_COMP_EN_BIT];
  assign low_wm_o  = low_wm_q;

  // Pending bit gated by its enable
  assign defl_interrupt_o = defl_pend_q & ctrl_q[hacd_reg_pkg::CTRL_DEFL_IE_BIT];
  assign infl_interrupt_o = infl_pend_q & ctrl_q[hacd_reg_pkg::CTRL_INFL_IE_BIT];

endmodule

// ==== hdl/hacd_run_encoder.sv ====
`timescale 1ns/1ps

module hacd_run_encoder (
  input  logic                              clk_i,
  input  logic                              rst_n_i,
  input  logic                              comp_en_i,
  // Word stream
  input  logic                              word_valid_i,
  input  logic                              word_last_i,
  input  logic [hacd_comp_pkg::WORD_W-1:0]  word_data_i,
  // Token stream
  output logic                              tok_valid_o,
  output logic                              tok_lit_o,
  output logic                              tok_last_o,
  output logic [hacd_comp_pkg::RUN_W-1:0]   tok_run_o,
  output logic [hacd_comp_pkg::WORD_W-1:0]  tok_data_o
);

  // Stage one
  logic                             s1_valid_q;
  logic                             s1_last_q;
  logic                             s1_zero_q;
  logic [hacd_comp_pkg::WORD_W-1:0] s1_data_q;

  // Stage two
  logic [hacd_comp_pkg::RUN_W-1:0]  run_q;
  logic [hacd_comp_pkg::RUN_W-1:0]  run_inc;
  logic                             emit;
  logic                             tok_valid_q;
  logic                             tok_lit_q;
  logic                             tok_last_q;
  logic [hacd_comp_pkg::RUN_W-1:0]  tok_run_q;
  logic [hacd_comp_pkg::WORD_W-1:0] tok_data_q;

  //////////////////////////////////////////////////////////////////////
  // Stage one registers and classifies
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      s1_valid_q <= 1'b0;
    end else begin
      s1_valid_q <= word_valid_i;
    end
  end

  // Payload follows the strobe
  always_ff @(posedge clk_i) begin
    if (word_valid_i) begin
      s1_data_q <= word_data_i;
      s1_last_q <= word_last_i;
      // Compression off makes every word a literal
      s1_zero_q <= comp_en_i & (word_data_i == '0);
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Stage two collapses zero runs
  //////////////////////////////////////////////////////////////////////

  assign run_inc = run_q + 1'b1;

  // Nonzero word or page end closes a token
  assign emit = s1_valid_q & (~s1_zero_q | s1_last_q);

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      run_q       <= '0;
      tok_valid_q <= 1'b0;
    end else begin
      tok_valid_q <= emit;
      // Count restarts after each token
      if (s1_valid_q) begin
        run_q <= emit ? '0 : run_inc;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (emit) begin
      // Trailing zero counts into the run
      tok_run_q  <= s1_zero_q ? run_inc : run_q;
      tok_lit_q  <= ~s1_zero_q;
      // A closing zero word carries zero data
      tok_data_q <= s1_data_q;
      tok_last_q <= s1_last_q;
    end
  end

  assign tok_valid_o = tok_valid_q;
  assign tok_lit_o   = tok_lit_q;
  assign tok_last_o  = tok_last_q;
  assign tok_run_o   = tok_run_q;
  assign tok_data_o  = tok_data_q;

endmodule

// ==== sim/tb_hacd.sv ====
`timescale 1ns/1ps

module tb_hacd;

  // Expected token
  // Data only compared for literals
  typedef struct packed {
    logic                             last;
    logic                             lit;
    logic [hacd_comp_pkg::RUN_W-1:0]  run;
    logic [hacd_comp_pkg::WORD_W-1:0] data;
  } tok_t;

  logic                                clk_i;
  logic                                rst_n_i;
  logic                                reg_valid_i;
  logic                                reg_write_i;
  logic [hacd_reg_pkg::REG_ADDR_W-1:0] reg_addr_i;
  logic [hacd_reg_pkg::REG_DATA_W-1:0] reg_wdata_i;
  logic [hacd_reg_pkg::REG_STRB_W-1:0] reg_wstrb_i;
  logic [hacd_reg_pkg::REG_DATA_W-1:0] reg_rdata_o;
  logic                                reg_ready_o;
  logic                                reg_error_o;
  logic                                word_valid_i;
  logic [hacd_comp_pkg::WORD_W-1:0]    word_data_i;
  logic                                word_last_i;
  logic                                tok_valid_o;
  logic [hacd_comp_pkg::RUN_W-1:0]     tok_run_o;
  logic [hacd_comp_pkg::WORD_W-1:0]    tok_data_o;
  logic                                tok_lit_o;
  logic                                tok_last_o;
  logic                                defl_interrupt_o;
  logic                                infl_interrupt_o;

  // Reference state
  tok_t        exp_q[$];
  logic [31:0] page_q[$];
  logic [31:0] seed;
  bit          comp_ref;
  bit          defl_ie_ref;
  bit          infl_ie_ref;
  int          low_wm_ref;
  // Token-ending words delayed by two cycles
  logic [1:0]  end_d;
  tok_t        head;

  hacd i_dut (.*);

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  ////////////////////////////////////////////////////////////////////
  // Error reporting
  ////////////////////////////////////////////////////////////////////

  task automatic stop_with_error(input string msg);
    $display("ERROR at %0t ns: %s", $time, msg);
    $display("Done: errors found");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp) else begin
      $display("MISMATCH at %0t ns: %s got 0x%0h expected 0x%0h", $time, name, got, exp);
      $display("Done: errors found");
      $fatal(1, "simulation stopped");
    end
  endtask

  ////////////////////////////////////////////////////////////////////
  // Stimulus helpers
  ////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // Never zero from a nonzero seed
  function automatic logic [31:0] next_rand();
    seed = xorshift(seed);
    return seed;
  endfunction

  // Random page with zero runs of 1 to 8 words
  // Kind 1 is all zero and kind 2 has a zero tail
  task automatic build_page(input int len, input int kind);
    int          zrun;
    logic [31:0] r;
    page_q.delete();
    zrun = 0;
    for (int i = 0; i < len; i++) begin
      r = next_rand();
      if (kind == 1 || (kind == 2 && i >= len / 2)) begin
        page_q.push_back('0);
      end else if (zrun > 0) begin
        page_q.push_back('0);
        zrun--;
      end else if (r[0]) begin
        zrun = {29'd0, r[3:1]};
        page_q.push_back('0);
      end else begin
        page_q.push_back(next_rand());
      end
    end
  endtask

  // Zero-run tokens of the current page
  // Returns the token count
  function automatic int encode_page(input bit comp, input bit push);
    int                              n;
    int                              last_i;
    logic [hacd_comp_pkg::RUN_W-1:0] run;
    tok_t                            t;
    n = 0;
    run = '0;
    last_i = page_q.size() - 1;
    foreach (page_q[i]) begin
      if (comp && page_q[i] == '0 && i != last_i) begin
        run = run + 7'd1;
      end else begin
        t.last = (i == last_i);
        t.lit  = !(comp && page_q[i] == '0);
        // Final zero of a page counts into its run
        t.run  = t.lit ? run : run + 7'd1;
        t.data = page_q[i];
        if (push) exp_q.push_back(t);
        n++;
        run = '0;
      end
    end
    return n;
  endfunction

  ////////////////////////////////////////////////////////////////////
  // Register bus
  ////////////////////////////////////////////////////////////////////

  task automatic reg_xfer(input bit wr, input logic [31:0] addr, input logic [31:0] data,
                          input logic [3:0] strb, output logic [31:0] rdata,
                          output logic err);
    int n;
    reg_valid_i = 1'b1;
    reg_write_i = wr;
    reg_addr_i  = addr;
    reg_wdata_i = data;
    reg_wstrb_i = strb;
    n = 0;
    do begin
      @(posedge clk_i);
      #1;
      n++;
      if (n > 16) stop_with_error("register bus never answered with ready");
    end while (!reg_ready_o);
    rdata = reg_rdata_o;
    err = reg_error_o;
    reg_valid_i = 1'b0;
  endtask

  task automatic reg_write(input logic [31:0] addr, input logic [31:0] data,
                           input logic [3:0] strb);
    logic [31:0] rd;
    logic        err;
    reg_xfer(1'b1, addr, data, strb, rd, err);
    check_eq("reg_error_o", 32'(err), 32'd0);
  endtask

  task automatic reg_check(input logic [31:0] addr, input logic [31:0] exp);
    logic [31:0] rd;
    logic        err;
    reg_xfer(1'b0, addr, '0, '0, rd, err);
    check_eq("reg_error_o", 32'(err), 32'd0);
    check_eq("reg_rdata_o", rd, exp);
  endtask

  task automatic set_ctrl(input bit comp, input bit defl_ie, input bit infl_ie);
    comp_ref    = comp;
    defl_ie_ref = defl_ie;
    infl_ie_ref = infl_ie;
    reg_write(hacd_reg_pkg::ADDR_CTRL, {29'd0, infl_ie, defl_ie, comp}, 4'hf);
  endtask

  task automatic set_wm(input int v);
    low_wm_ref = v;
    reg_write(hacd_reg_pkg::ADDR_LOW_WM, 32'(v), 4'hf);
  endtask

  ////////////////////////////////////////////////////////////////////
  // Page traffic
  ////////////////////////////////////////////////////////////////////

  task automatic send_page();
    logic [31:0] r;
    for (int i = 0; i < page_q.size(); i++) begin
      word_valid_i = 1'b1;
      word_data_i  = page_q[i];
      word_last_i  = (i == page_q.size() - 1);
      @(posedge clk_i);
      #1;
      word_valid_i = 1'b0;
      word_last_i  = 1'b0;
      r = next_rand();
      // Idle gap after roughly one word in four
      if (r[1:0] == 2'd0) begin
        @(posedge clk_i);
        #1;
      end
    end
  endtask

  task automatic finish_page(input int n_tok);
    int          n;
    bit          defl;
    logic [31:0] stat;
    defl = (n_tok <= low_wm_ref);
    stat = 32'd1 << (defl ? hacd_reg_pkg::STAT_DEFL_BIT : hacd_reg_pkg::STAT_INFL_BIT);
    n = 0;
    while (exp_q.size() != 0) begin
      @(posedge clk_i);
      #1;
      n++;
      if (n > 20) stop_with_error("expected tokens never came out");
    end
    if ((defl && defl_ie_ref) || (!defl && infl_ie_ref)) begin
      n = 0;
      while (!(defl_interrupt_o || infl_interrupt_o)) begin
        @(posedge clk_i);
        #1;
        n++;
        if (n > 10) stop_with_error("interrupt did not assert after page end");
      end
    end else begin
      // Status lands two cycles after the last token
      repeat (2) @(posedge clk_i);
      #1;
    end
    check_eq("defl_interrupt_o", 32'(defl_interrupt_o), 32'(defl & defl_ie_ref));
    check_eq("infl_interrupt_o", 32'(infl_interrupt_o), 32'(!defl & infl_ie_ref));
    reg_check(hacd_reg_pkg::ADDR_PAGE_TOKENS, 32'(n_tok));
    reg_check(hacd_reg_pkg::ADDR_STATUS, stat);
    // Zeros leave pending bits alone and ones clear them
    reg_write(hacd_reg_pkg::ADDR_STATUS, 32'h0, 4'hf);
    reg_check(hacd_reg_pkg::ADDR_STATUS, stat);
    check_eq("defl_interrupt_o", 32'(defl_interrupt_o), 32'(defl & defl_ie_ref));
    check_eq("infl_interrupt_o", 32'(infl_interrupt_o), 32'(!defl & infl_ie_ref));
    reg_write(hacd_reg_pkg::ADDR_STATUS, 32'h3, 4'h1);
    reg_check(hacd_reg_pkg::ADDR_STATUS, 32'h0);
    check_eq("defl_interrupt_o", 32'(defl_interrupt_o), 32'd0);
    check_eq("infl_interrupt_o", 32'(infl_interrupt_o), 32'd0);
  endtask

  // Replays page_q through the DUT
  task automatic play_page();
    int n;
    n = encode_page(comp_ref, 1'b1);
    send_page();
    finish_page(n);
  endtask

  ////////////////////////////////////////////////////////////////////
  // Token compare
  ////////////////////////////////////////////////////////////////////

  always @(negedge clk_i) begin
    if (!rst_n_i) begin
      end_d = '0;
    end else begin
      check_eq("tok_valid_o", 32'(tok_valid_o), 32'(end_d[1]));
      end_d = {end_d[0], word_valid_i & (word_last_i | ~comp_ref | (word_data_i != '0))};
      if (tok_valid_o) begin
        if (exp_q.size() == 0) stop_with_error("token seen with none expected");
        head = exp_q.pop_front();
        check_eq("tok_run_o", 32'(tok_run_o), 32'(head.run));
        check_eq("tok_lit_o", 32'(tok_lit_o), 32'(head.lit));
        check_eq("tok_last_o", 32'(tok_last_o), 32'(head.last));
        if (head.lit) check_eq("tok_data_o", tok_data_o, head.data);
      end
    end
  end

  ////////////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////////////

  initial begin
    logic [31:0] rd;
    logic        err;
    rst_n_i      = 1'b0;
    reg_valid_i  = 1'b0;
    reg_write_i  = 1'b0;
    reg_addr_i   = '0;
    reg_wdata_i  = '0;
    reg_wstrb_i  = '0;
    word_valid_i = 1'b0;
    word_data_i  = '0;
    word_last_i  = 1'b0;
    seed         = 32'h87e2_e5ff;
    comp_ref     = 1'b0;
    defl_ie_ref  = 1'b0;
    infl_ie_ref  = 1'b0;
    low_wm_ref   = 16;
    repeat (4) @(posedge clk_i);
    #1;
    rst_n_i = 1'b1;

    // Idle outputs and reset values
    check_eq("reg_ready_o", 32'(reg_ready_o), 32'd0);
    check_eq("reg_error_o", 32'(reg_error_o), 32'd0);
    check_eq("defl_interrupt_o", 32'(defl_interrupt_o), 32'd0);
    check_eq("infl_interrupt_o", 32'(infl_interrupt_o), 32'd0);
    reg_check(hacd_reg_pkg::ADDR_CTRL, 32'd0);
    reg_check(hacd_reg_pkg::ADDR_LOW_WM, 32'd16);
    reg_check(hacd_reg_pkg::ADDR_STATUS, 32'd0);
    reg_check(hacd_reg_pkg::ADDR_PAGE_TOKENS, 32'd0);

    // Byte 1 alone misses the watermark field
    reg_write(hacd_reg_pkg::ADDR_LOW_WM, 32'h0000_2a25, 4'b0010);
    reg_check(hacd_reg_pkg::ADDR_LOW_WM, 32'd16);
    reg_write(hacd_reg_pkg::ADDR_LOW_WM, 32'h0000_2a25, 4'b0001);
    reg_check(hacd_reg_pkg::ADDR_LOW_WM, 32'h25);
    reg_write(hacd_reg_pkg::ADDR_CTRL, 32'h0000_ff06, 4'b0001);
    reg_check(hacd_reg_pkg::ADDR_CTRL, 32'h6);

    // Unmapped offsets answer with error and write nothing
    reg_xfer(1'b0, 32'h0000_0010, '0, '0, rd, err);
    check_eq("reg_error_o", 32'(err), 32'd1);
    reg_xfer(1'b1, 32'h0000_0040, 32'hffff_ffff, 4'hf, rd, err);
    check_eq("reg_error_o", 32'(err), 32'd1);
    reg_check(hacd_reg_pkg::ADDR_CTRL, 32'h6);
    // Read-only token count
    reg_write(hacd_reg_pkg::ADDR_PAGE_TOKENS, 32'h55, 4'hf);
    reg_check(hacd_reg_pkg::ADDR_PAGE_TOKENS, 32'd0);

    // Compression on with both interrupts enabled
    set_ctrl(1'b1, 1'b1, 1'b1);
    set_wm(16);
    build_page(64, 1);
    play_page();
    build_page(1, 1);
    play_page();
    for (int p = 0; p < 12; p++) begin
      build_page(int'(next_rand() % 64) + 1, p % 3);
      play_page();
    end

    // Count equal to the watermark and then one above it
    build_page(40, 0);
    set_wm(encode_page(1'b1, 1'b0));
    play_page();
    set_wm(low_wm_ref - 1);
    play_page();

    // Compression off makes every word a literal
    set_ctrl(1'b0, 1'b0, 1'b0);
    set_wm(16);
    for (int p = 0; p < 4; p++) begin
      build_page(int'(next_rand() % 64) + 1, p % 3);
      play_page();
    end

    // Deflate interrupt only
    set_ctrl(1'b1, 1'b1, 1'b0);
    for (int p = 0; p < 6; p++) begin
      build_page(int'(next_rand() % 64) + 1, p % 3);
      play_page();
    end

    $display("Done: no errors");
    $finish;
  end

endmodule
